//--- source/wro_req_pkg.sv
// ====================
// Request field widths, tag and payload types, and the request address union
// ====================

package wro_req_pkg;

    // Only the low LINE_ADDR_BITS of a line address carry meaning
    localparam int LINE_ADDR_BITS = 42;
    localparam int REQ_TAG_BITS = 10;
    localparam int WR_DATA_BITS = 64;

    typedef logic [LINE_ADDR_BITS-1:0] t_line_addr;

    // Tag returned with the response of a read or a write
    typedef logic [REQ_TAG_BITS-1:0] t_req_tag;

    // One write payload word
    typedef logic [WR_DATA_BITS-1:0] t_wr_data;

    // Upper and lower 32-bit halves of an address, folded together for hashing
    typedef struct packed
    {
        logic [31:0] hi;
        logic [31:0] lo;
    } t_addr_halves;

    // ====================
    // Request address word
    // ====================

    // The same 64 bits read either as a zero-extended line address or as
    // two halves for hash folding
    typedef union packed
    {
        logic [63:0] line_addr;
        t_addr_halves halves;
    } t_req_addr;

endpackage

//--- source/wro_hash_pkg.sv
// ====================
// Hash width default and the 32-bit mixing function
// ====================

package wro_hash_pkg;

    // Default number of hash bits kept per request
    localparam int DEFAULT_HASH_BITS = 9;

    // Odd multiplier of the mixing step
    localparam logic [31:0] HASH32_MULT = 32'h045D9F3B;

    // ====================
    // Integer mixing function
    // ====================

    // Fold the high half into the low half, multiply to spread the bits
    // upward, then fold once more so the low bits depend on every input bit
    function automatic logic [31:0] hash32(input logic [31:0] key);
        logic [31:0] h;
        logic [63:0] prod;

        h = key ^ (key >> 16);
        prod = 64'(h) * 64'(HASH32_MULT);
        // Product is kept modulo 2^32
        h = prod[31:0];
        h = h ^ (h >> 16);
        return h;
    endfunction

endpackage

//--- source/wro_read_lane.sv
// ====================
// Read lane: first request register stage and read address hash
// ====================

`timescale 1ns/1ns

module wro_read_lane
    import wro_req_pkg::*;
    import wro_hash_pkg::*;
#(
    parameter int ADDR_HASH_BITS = DEFAULT_HASH_BITS
)
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load,
    input  logic                      squash_rd,
    input  logic                      rd_valid,
    input  t_req_addr                 rd_addr,
    input  t_req_tag                  rd_tag,
    output logic                      lane_valid,
    output t_req_addr                 lane_addr,
    output t_req_tag                  lane_tag,
    output logic [ADDR_HASH_BITS-1:0] lane_hash
);

    // Full 32-bit hash of the incoming address, before truncation
    logic [31:0] hash_full;

    // Fold the two halves of the address and mix them
    assign hash_full = hash32(rd_addr.halves.hi ^ rd_addr.halves.lo);

    // Valid bit is control state and follows reset
    always_ff @(posedge clk)
    begin
        if (reset)
            lane_valid <= 1'b0;
        else if (squash_rd)
            // The read left alone during a conflict, so the lane is free
            lane_valid <= 1'b0;
        else if (load)
            lane_valid <= rd_valid;
    end

    // Payload and hash are captured together with the valid bit
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            lane_addr <= rd_addr;
            lane_tag  <= rd_tag;
            lane_hash <= hash_full[ADDR_HASH_BITS-1:0];
        end
    end

endmodule

//--- source/wro_write_lane.sv
// ====================
// Write lane: first request register stage and write address hash
// ====================

`timescale 1ns/1ns

module wro_write_lane
    import wro_req_pkg::*;
    import wro_hash_pkg::*;
#(
    parameter int ADDR_HASH_BITS = DEFAULT_HASH_BITS
)
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load,
    input  logic                      wr_valid,
    input  t_req_addr                 wr_addr,
    input  t_req_tag                  wr_tag,
    input  t_wr_data                  wr_data,
    output logic                      lane_valid,
    output t_req_addr                 lane_addr,
    output t_req_tag                  lane_tag,
    output t_wr_data                  lane_data,
    output logic [ADDR_HASH_BITS-1:0] lane_hash
);

    // Full 32-bit hash of the incoming write address
    logic [31:0] hash_full;

    // Same folding rule as the read lane so equal addresses give equal hashes
    assign hash_full = hash32(wr_addr.halves.hi ^ wr_addr.halves.lo);

    // ====================
    // Lane register
    // ====================

    // A write held back by a conflict simply stays here until load returns,
    // so only reset and load touch the valid bit
    always_ff @(posedge clk)
    begin
        if (reset)
            lane_valid <= 1'b0;
        else if (load)
            lane_valid <= wr_valid;
    end

    // Address, tag, payload and hash move as one request
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            lane_addr <= wr_addr;
            lane_tag  <= wr_tag;
            lane_data <= wr_data;
            lane_hash <= hash_full[ADDR_HASH_BITS-1:0];
        end
    end

endmodule

//--- source/wro_order_stage.sv
// ====================
// Order stage: read/write conflict check, pipeline move control and output
// registers with the index-0 hashes
// ====================

`timescale 1ns/1ns

module wro_order_stage
    import wro_req_pkg::*;
    import wro_hash_pkg::*;
#(
    parameter int ADDR_HASH_BITS = DEFAULT_HASH_BITS
)
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      deq,
    input  logic                      rd_lane_valid,
    input  t_req_addr                 rd_lane_addr,
    input  t_req_tag                  rd_lane_tag,
    input  logic [ADDR_HASH_BITS-1:0] rd_lane_hash,
    input  logic                      wr_lane_valid,
    input  t_req_addr                 wr_lane_addr,
    input  t_req_tag                  wr_lane_tag,
    input  t_wr_data                  wr_lane_data,
    input  logic [ADDR_HASH_BITS-1:0] wr_lane_hash,
    output logic                      load,
    output logic                      squash_rd,
    output logic                      in_ready,
    output logic                      out_rd_valid,
    output t_req_addr                 out_rd_addr,
    output t_req_tag                  out_rd_tag,
    output logic                      out_wr_valid,
    output t_req_addr                 out_wr_addr,
    output t_req_tag                  out_wr_tag,
    output t_wr_data                  out_wr_data,
    output logic [ADDR_HASH_BITS-1:0] rd_hash [0:1],
    output logic [ADDR_HASH_BITS-1:0] wr_hash [0:1],
    output logic                      rd_hash_valid [0:1],
    output logic                      wr_hash_valid [0:1]
);

    // Read and write in the lanes hash to the same value
    logic conflict;
    // Output registers take the lane contents this cycle
    logic move_out;
    // Registered hashes that travel with the outputs
    logic [ADDR_HASH_BITS-1:0] rd_hash_q;
    logic [ADDR_HASH_BITS-1:0] wr_hash_q;
    logic rd_hash_valid_q;
    logic wr_hash_valid_q;

    // ====================
    // Move control
    // ====================

    assign conflict = rd_lane_valid && wr_lane_valid && (rd_lane_hash == wr_lane_hash);

    // The output stage advances when consumed or when it holds nothing
    assign move_out = deq || !(out_rd_valid || out_wr_valid);

    // Lanes refill when their contents move on or they are empty. A conflict
    // keeps the write in place for one more output cycle
    assign load = (move_out || !(rd_lane_valid || wr_lane_valid)) && !conflict;
    assign in_ready = load;

    // The read goes out alone during a conflict, so its lane copy is dropped
    assign squash_rd = move_out && conflict;

    // ====================
    // Output stage
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_rd_valid    <= 1'b0;
            out_wr_valid    <= 1'b0;
            rd_hash_valid_q <= 1'b0;
            wr_hash_valid_q <= 1'b0;
        end
        else if (move_out)
        begin
            out_rd_valid    <= rd_lane_valid;
            // Write is withheld and taken from the lane a cycle later
            out_wr_valid    <= wr_lane_valid && !conflict;
            rd_hash_valid_q <= rd_lane_valid;
            wr_hash_valid_q <= wr_lane_valid && !conflict;
        end
    end

    // Payload moves with the valid bits and holds while deq is low
    always_ff @(posedge clk)
    begin
        if (move_out)
        begin
            out_rd_addr <= rd_lane_addr;
            out_rd_tag  <= rd_lane_tag;
            out_wr_addr <= wr_lane_addr;
            out_wr_tag  <= wr_lane_tag;
            out_wr_data <= wr_lane_data;
            rd_hash_q   <= rd_lane_hash;
            wr_hash_q   <= wr_lane_hash;
        end
    end

    // Index 1 is the lane stage, index 0 the output stage
    always_comb
    begin
        rd_hash[1]       = rd_lane_hash;
        wr_hash[1]       = wr_lane_hash;
        rd_hash_valid[1] = rd_lane_valid;
        wr_hash_valid[1] = wr_lane_valid;
        rd_hash[0]       = rd_hash_q;
        wr_hash[0]       = wr_hash_q;
        rd_hash_valid[0] = rd_hash_valid_q;
        wr_hash_valid[0] = wr_hash_valid_q;
    end

endmodule

//--- source/wro_cam_group.sv
// ====================
// Write-read ordering front end for one request group
// ====================

`timescale 1ns/1ns

module wro_cam_group
    import wro_req_pkg::*;
    import wro_hash_pkg::*;
#(
    parameter int ADDR_HASH_BITS = DEFAULT_HASH_BITS
)
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      rd_valid,
    input  t_req_addr                 rd_addr,
    input  t_req_tag                  rd_tag,
    input  logic                      wr_valid,
    input  t_req_addr                 wr_addr,
    input  t_req_tag                  wr_tag,
    input  t_wr_data                  wr_data,
    output logic                      in_ready,
    output logic                      out_rd_valid,
    output t_req_addr                 out_rd_addr,
    output t_req_tag                  out_rd_tag,
    output logic                      out_wr_valid,
    output t_req_addr                 out_wr_addr,
    output t_req_tag                  out_wr_tag,
    output t_wr_data                  out_wr_data,
    input  logic                      deq,
    output logic [ADDR_HASH_BITS-1:0] rd_hash [0:1],
    output logic [ADDR_HASH_BITS-1:0] wr_hash [0:1],
    output logic                      rd_hash_valid [0:1],
    output logic                      wr_hash_valid [0:1]
);

    // Lane capture and read squash from the order stage
    logic load;
    logic squash_rd;
    // Registered read lane contents
    logic rd_lane_valid;
    t_req_addr rd_lane_addr;
    t_req_tag rd_lane_tag;
    logic [ADDR_HASH_BITS-1:0] rd_lane_hash;
    // Registered write lane contents
    logic wr_lane_valid;
    t_req_addr wr_lane_addr;
    t_req_tag wr_lane_tag;
    t_wr_data wr_lane_data;
    logic [ADDR_HASH_BITS-1:0] wr_lane_hash;

    wro_read_lane #(.ADDR_HASH_BITS(ADDR_HASH_BITS)) read_lane_i
    (
        .clk, .reset, .load, .squash_rd,
        .rd_valid, .rd_addr, .rd_tag,
        .lane_valid(rd_lane_valid), .lane_addr(rd_lane_addr),
        .lane_tag(rd_lane_tag), .lane_hash(rd_lane_hash)
    );

    wro_write_lane #(.ADDR_HASH_BITS(ADDR_HASH_BITS)) write_lane_i
    (
        .clk, .reset, .load,
        .wr_valid, .wr_addr, .wr_tag, .wr_data,
        .lane_valid(wr_lane_valid), .lane_addr(wr_lane_addr),
        .lane_tag(wr_lane_tag), .lane_data(wr_lane_data), .lane_hash(wr_lane_hash)
    );

    // Second stage orders a conflicting pair and presents the outputs
    wro_order_stage #(.ADDR_HASH_BITS(ADDR_HASH_BITS)) order_stage_i
    (
        .clk, .reset, .deq,
        .rd_lane_valid, .rd_lane_addr, .rd_lane_tag, .rd_lane_hash,
        .wr_lane_valid, .wr_lane_addr, .wr_lane_tag, .wr_lane_data, .wr_lane_hash,
        .load, .squash_rd, .in_ready,
        .out_rd_valid, .out_rd_addr, .out_rd_tag,
        .out_wr_valid, .out_wr_addr, .out_wr_tag, .out_wr_data,
        .rd_hash, .wr_hash, .rd_hash_valid, .wr_hash_valid
    );

endmodule

//--- verif/wro_clock_gen.sv
// ====================
// Testbench clock and power-on reset
// ====================

`timescale 1ns/1ns

module wro_clock_gen
#(
    parameter int PERIOD_NS = 20,
    parameter int RESET_CYCLES = 16
)
(
    output logic clk,
    output logic reset
);

    // Free-running clock, low for the first half period
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset drops on a rising edge like any other registered input
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- verif/wro_cam_group_properties.sv
// ====================
// Order stage checks for reset state, output hold and conflict order, and their bind
// ====================

`timescale 1ns/1ns

module wro_cam_group_properties
    import wro_req_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      deq,
    input logic      conflict,
    input logic      move_out,
    input logic      rd_lane_valid,
    input logic      wr_lane_valid,
    input t_req_addr wr_lane_addr,
    input logic      rd_hash_valid_q,
    input logic      wr_hash_valid_q,
    input logic      out_rd_valid,
    input t_req_addr out_rd_addr,
    input t_req_tag  out_rd_tag,
    input logic      out_wr_valid,
    input t_req_addr out_wr_addr,
    input t_req_tag  out_wr_tag,
    input t_wr_data  out_wr_data
);

    // Every valid of both stages is clear in the cycle after a reset cycle
    reset_clears_valids: assert property (@(posedge clk)
        reset |=> !out_rd_valid && !out_wr_valid && !rd_lane_valid && !wr_lane_valid
                  && !rd_hash_valid_q && !wr_hash_valid_q)
        else $error("A valid bit is set right after reset");

    // Unconsumed outputs stay exactly as they are
    hold_without_deq: assert property (@(posedge clk) disable iff (reset)
        (out_rd_valid || out_wr_valid) && !deq
        |=> $stable(out_rd_valid) && $stable(out_wr_valid) && $stable(out_rd_addr)
            && $stable(out_rd_tag) && $stable(out_wr_addr) && $stable(out_wr_tag)
            && $stable(out_wr_data))
        else $error("Outputs changed while deq was low");

    // A conflicting read leaves alone while its write waits unchanged in the lane
    read_before_write: assert property (@(posedge clk) disable iff (reset)
        conflict && move_out
        |=> out_rd_valid && !out_wr_valid && !rd_lane_valid && wr_lane_valid
            && $stable(wr_lane_addr))
        else $error("Conflicting pair was not split into a read first and a held write");

endmodule

bind wro_order_stage wro_cam_group_properties props_i
(
    .clk, .reset, .deq, .conflict, .move_out,
    .rd_lane_valid, .wr_lane_valid, .wr_lane_addr, .rd_hash_valid_q, .wr_hash_valid_q,
    .out_rd_valid, .out_rd_addr, .out_rd_tag,
    .out_wr_valid, .out_wr_addr, .out_wr_tag, .out_wr_data
);

//--- verif/wro_cam_group_tb.sv
// ====================
// Table-driven testbench for the write-read ordering front end, with
// per-channel expected queues, a hash model, a watchdog and the final report
// ====================

`timescale 1ns/1ns

module wro_cam_group_tb
    import wro_req_pkg::*;
();

    localparam int HASH_BITS = 9;
    localparam int NUM_ENTRIES = 48;
    localparam int WATCHDOG_CYCLES = 40 * NUM_ENTRIES;

    logic clk;
    logic reset;
    logic rd_valid;
    t_req_addr rd_addr;
    t_req_tag rd_tag;
    logic wr_valid;
    t_req_addr wr_addr;
    t_req_tag wr_tag;
    t_wr_data wr_data;
    logic deq;
    logic in_ready;
    logic out_rd_valid;
    t_req_addr out_rd_addr;
    t_req_tag out_rd_tag;
    logic out_wr_valid;
    t_req_addr out_wr_addr;
    t_req_tag out_wr_tag;
    t_wr_data out_wr_data;
    logic [HASH_BITS-1:0] rd_hash [0:1];
    logic [HASH_BITS-1:0] wr_hash [0:1];
    logic rd_hash_valid [0:1];
    logic wr_hash_valid [0:1];

    // Stimulus table, one row per offered read/write pair
    logic tbl_rd_v [NUM_ENTRIES];
    logic tbl_wr_v [NUM_ENTRIES];
    logic tbl_conf [NUM_ENTRIES];
    logic tbl_strict [NUM_ENTRIES];
    logic [7:0] tbl_deq [NUM_ENTRIES];
    logic [63:0] tbl_rd_addr [NUM_ENTRIES];
    logic [63:0] tbl_wr_addr [NUM_ENTRIES];
    logic [63:0] tbl_wr_data [NUM_ENTRIES];
    int n_entries = 0;

    // Expected requests per channel, oldest first
    t_req_addr exp_rd_addr [$];
    t_req_tag exp_rd_tag [$];
    int exp_rd_cyc [$];
    logic exp_rd_strict [$];
    t_req_addr exp_wr_addr [$];
    t_req_tag exp_wr_tag [$];
    t_wr_data exp_wr_data [$];
    int exp_wr_cyc [$];
    logic exp_wr_strict [$];
    logic exp_wr_conf [$];

    // Most recently accepted addresses, which a valid lane stage still holds
    t_req_addr last_rd_addr = '0;
    t_req_addr last_wr_addr = '0;

    logic [31:0] lcg_state = 32'd79574;
    int cyc = 0;
    int rd_done_cyc = -1;
    int stall_cycles = 0;
    int mismatch_count = 0;
    int other_count = 0;
    // Flags of the row being offered, read by the monitor at acceptance
    logic cur_conf = 1'b0;
    logic cur_strict = 1'b0;

    wro_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) clock_gen_i (.clk, .reset);

    wro_cam_group #(.ADDR_HASH_BITS(HASH_BITS)) dut_i
    (
        .clk, .reset, .rd_valid, .rd_addr, .rd_tag,
        .wr_valid, .wr_addr, .wr_tag, .wr_data, .in_ready,
        .out_rd_valid, .out_rd_addr, .out_rd_tag,
        .out_wr_valid, .out_wr_addr, .out_wr_tag, .out_wr_data,
        .deq, .rd_hash, .wr_hash, .rd_hash_valid, .wr_hash_valid
    );

    // ====================
    // Models and helpers
    // ====================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Random line address, zero-extended to the full address word
    function automatic logic [63:0] make_addr();
        logic [31:0] a;
        logic [31:0] b;
        a = lcg_next();
        b = lcg_next();
        return {a, b} & ((64'd1 << LINE_ADDR_BITS) - 64'd1);
    endfunction

    // Fold hi into lo, xor-shift, multiply mod 2^32, xor-shift again, keep the low bits
    function automatic logic [HASH_BITS-1:0] rule_hash(input logic [63:0] addr);
        logic [31:0] x;
        logic [63:0] m;
        x = addr[63:32] ^ addr[31:0];
        x = x ^ {16'h0000, x[31:16]};
        m = {32'h0, x} * 64'h0000_0000_045D_9F3B;
        x = m[31:0] ^ {16'h0000, m[31:16]};
        return x[HASH_BITS-1:0];
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        mismatch_count++;
        $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
    endtask

    // Write addresses are redrawn until the hash relation asked for holds
    task automatic add_entry(input logic rd_v, input logic wr_v, input logic want_conf,
                             input logic strict, input logic [7:0] deq_pat);
        logic [63:0] ra;
        logic [63:0] wa;
        int tries;
        ra = make_addr();
        wa = make_addr();
        tries = 0;
        while (rd_v && wr_v && tries < 100000
               && (wa == ra || ((rule_hash(ra) == rule_hash(wa)) != want_conf)))
        begin
            wa = make_addr();
            tries++;
        end
        tbl_rd_v[n_entries] = rd_v;
        tbl_wr_v[n_entries] = wr_v;
        tbl_conf[n_entries] = rd_v && wr_v && (rule_hash(ra) == rule_hash(wa));
        tbl_strict[n_entries] = strict;
        tbl_deq[n_entries] = deq_pat;
        tbl_rd_addr[n_entries] = ra;
        tbl_wr_addr[n_entries] = wa;
        tbl_wr_data[n_entries] = {lcg_next(), lcg_next()};
        n_entries++;
    endtask

    task automatic build_table();
        logic [31:0] r;
        // Deq held high, so latency is checked exactly
        repeat (4) add_entry(1'b1, 1'b0, 1'b0, 1'b1, 8'hFF);
        repeat (4) add_entry(1'b0, 1'b1, 1'b0, 1'b1, 8'hFF);
        repeat (4) add_entry(1'b1, 1'b1, 1'b0, 1'b1, 8'hFF);
        repeat (4) add_entry(1'b1, 1'b1, 1'b1, 1'b1, 8'hFF);
        // Idle rows keep deq high while the last pairs drain
        repeat (2) add_entry(1'b0, 1'b0, 1'b0, 1'b1, 8'hFF);
        // Random mix, the top deq bit is set so deq returns within eight cycles
        repeat (30)
        begin
            r = lcg_next();
            add_entry(r[31], r[30], r[31] & r[30] & r[29], 1'b0, r[23:16] | 8'h80);
        end
    endtask

    // ====================
    // Driver
    // ====================

    // Offer one row from a rising edge and hold it until in_ready takes it
    task automatic apply_entry(input int idx);
        logic accepted;
        logic [2:0] step;
        accepted = 1'b0;
        step = 3'd0;
        cur_conf = tbl_conf[idx];
        cur_strict = tbl_strict[idx];
        rd_valid <= tbl_rd_v[idx];
        rd_addr <= tbl_rd_addr[idx];
        rd_tag <= t_req_tag'(idx);
        wr_valid <= tbl_wr_v[idx];
        wr_addr <= tbl_wr_addr[idx];
        wr_tag <= t_req_tag'(idx) | 10'h200;
        wr_data <= tbl_wr_data[idx];
        while (!accepted)
        begin
            deq <= tbl_deq[idx][step];
            @(negedge clk);
            accepted = in_ready;
            @(posedge clk);
            step = step + 3'd1;
        end
    endtask

    // ====================
    // Monitor and scoreboard
    // ====================

    task automatic check_read();
        int acc;
        if (exp_rd_addr.size() == 0)
        begin
            other_count++;
            $display("Read tag %h left at %0t with no read outstanding", out_rd_tag, $time);
        end
        else
        begin
            acc = exp_rd_cyc.pop_front();
            assert (out_rd_addr == exp_rd_addr[0])
            else report_mismatch("out_rd_addr", exp_rd_addr[0], out_rd_addr);
            assert (out_rd_tag == exp_rd_tag[0])
            else report_mismatch("out_rd_tag", 64'(exp_rd_tag[0]), 64'(out_rd_tag));
            if (exp_rd_strict.pop_front())
            begin
                assert (cyc - acc == 2)
                else
                begin
                    other_count++;
                    $display("Read tag %h took %0d cycles instead of 2", out_rd_tag, cyc - acc);
                end
            end
            void'(exp_rd_addr.pop_front());
            void'(exp_rd_tag.pop_front());
            rd_done_cyc = acc;
        end
    endtask

    task automatic check_write();
        int acc;
        logic conf;
        if (exp_wr_addr.size() == 0)
        begin
            other_count++;
            $display("Write tag %h left at %0t with no write outstanding", out_wr_tag, $time);
        end
        else
        begin
            acc = exp_wr_cyc.pop_front();
            conf = exp_wr_conf.pop_front();
            assert (out_wr_addr == exp_wr_addr[0])
            else report_mismatch("out_wr_addr", exp_wr_addr[0], out_wr_addr);
            assert (out_wr_tag == exp_wr_tag[0])
            else report_mismatch("out_wr_tag", 64'(exp_wr_tag[0]), 64'(out_wr_tag));
            assert (out_wr_data == exp_wr_data[0])
            else report_mismatch("out_wr_data", exp_wr_data[0], out_wr_data);
            // The partner read must have been consumed in an earlier cycle
            if (conf)
            begin
                assert (rd_done_cyc >= acc)
                else
                begin
                    other_count++;
                    $display("Write tag %h left before its conflicting read", out_wr_tag);
                end
            end
            if (exp_wr_strict.pop_front())
            begin
                assert (cyc - acc == (conf ? 3 : 2))
                else
                begin
                    other_count++;
                    $display("Write tag %h took %0d cycles to leave", out_wr_tag, cyc - acc);
                end
            end
            void'(exp_wr_addr.pop_front());
            void'(exp_wr_tag.pop_front());
            void'(exp_wr_data.pop_front());
        end
    endtask

    // Sampled mid-cycle, where inputs, outputs and in_ready are all settled
    always @(negedge clk)
    begin
        if (!reset)
        begin
            cyc = cyc + 1;
            // Index-0 hash valids travel with the output valids
            assert (rd_hash_valid[0] == out_rd_valid)
            else report_mismatch("rd_hash_valid[0]", 64'(out_rd_valid), 64'(rd_hash_valid[0]));
            assert (wr_hash_valid[0] == out_wr_valid)
            else report_mismatch("wr_hash_valid[0]", 64'(out_wr_valid), 64'(wr_hash_valid[0]));
            if (rd_hash_valid[0])
            begin
                assert (rd_hash[0] == rule_hash(out_rd_addr))
                else report_mismatch("rd_hash[0]", 64'(rule_hash(out_rd_addr)), 64'(rd_hash[0]));
            end
            if (wr_hash_valid[0])
            begin
                assert (wr_hash[0] == rule_hash(out_wr_addr))
                else report_mismatch("wr_hash[0]", 64'(rule_hash(out_wr_addr)), 64'(wr_hash[0]));
            end
            // A valid lane stage holds the request accepted last on its channel
            if (rd_hash_valid[1])
            begin
                assert (rd_hash[1] == rule_hash(last_rd_addr))
                else report_mismatch("rd_hash[1]", 64'(rule_hash(last_rd_addr)), 64'(rd_hash[1]));
            end
            if (wr_hash_valid[1])
            begin
                assert (wr_hash[1] == rule_hash(last_wr_addr))
                else report_mismatch("wr_hash[1]", 64'(rule_hash(last_wr_addr)), 64'(wr_hash[1]));
            end
            // Write first, so a read leaving in this same cycle does not count as earlier
            if (deq && out_wr_valid)
                check_write();
            if (deq && out_rd_valid)
                check_read();
            if (!in_ready && !deq)
                stall_cycles = stall_cycles + 1;
            if (in_ready && rd_valid)
            begin
                exp_rd_addr.push_back(rd_addr);
                exp_rd_tag.push_back(rd_tag);
                exp_rd_cyc.push_back(cyc);
                exp_rd_strict.push_back(cur_strict);
                last_rd_addr = rd_addr;
            end
            if (in_ready && wr_valid)
            begin
                exp_wr_addr.push_back(wr_addr);
                exp_wr_tag.push_back(wr_tag);
                exp_wr_data.push_back(wr_data);
                exp_wr_cyc.push_back(cyc);
                exp_wr_strict.push_back(cur_strict);
                exp_wr_conf.push_back(cur_conf);
                last_wr_addr = wr_addr;
            end
        end
    end

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        rd_valid = 1'b0;
        rd_addr = '0;
        rd_tag = '0;
        wr_valid = 1'b0;
        wr_addr = '0;
        wr_tag = '0;
        wr_data = '0;
        deq = 1'b0;
        build_table();
        while (reset)
            @(posedge clk);
        @(negedge clk);
        assert (!out_rd_valid && !out_wr_valid && !rd_hash_valid[0] && !rd_hash_valid[1]
                && !wr_hash_valid[0] && !wr_hash_valid[1] && in_ready)
        else
        begin
            other_count++;
            $display("Outputs are not idle or in_ready is low after reset");
        end
        @(posedge clk);
        for (int i = 0; i < NUM_ENTRIES; i++)
            apply_entry(i);
        // Stop offering and drain everything still in flight
        rd_valid <= 1'b0;
        wr_valid <= 1'b0;
        deq <= 1'b1;
        while (exp_rd_addr.size() != 0 || exp_wr_addr.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        assert (stall_cycles > 0)
        else
        begin
            other_count++;
            $display("in_ready never dropped while deq was low, so back-pressure was not exercised");
        end
        $display("Error count: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Bound on the whole run, sized from the table length
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with requests still outstanding", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- wro_cam_group.f
source/wro_req_pkg.sv
source/wro_hash_pkg.sv
source/wro_read_lane.sv
source/wro_write_lane.sv
source/wro_order_stage.sv
source/wro_cam_group.sv
verif/wro_clock_gen.sv
verif/wro_cam_group_properties.sv
verif/wro_cam_group_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench and RTL with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module wro_cam_group_tb -f wro_cam_group.f -o wro_cam_group_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/wro_cam_group_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
